//--- common/switch_pkg.sv
`default_nettype none

package switch_pkg;

  // word address width of the fabric.
  parameter int addr_width_p = 14;

  parameter int data_width_p   = 32;
  parameter int src_id_width_p = 4;

  typedef logic [addr_width_p-1:0]   addr_t;
  typedef logic [data_width_p-1:0]   data_t;
  typedef logic [src_id_width_p-1:0] src_id_t;
  typedef logic [1:0]                part_sel_t;

  // byte address, word address with the part select below it.
  typedef logic [addr_width_p+1:0] epa_t;

  typedef struct packed {
    addr_t     addr;
    part_sel_t part_sel;
    data_t     data;
    src_id_t   src_id;
  } req_pkt_s;

  typedef struct packed {
    data_t   data;
    src_id_t src_id;
  } ret_pkt_s;

  typedef enum logic [1:0] {
    e_ready = 2'd0,
    e_send0 = 2'd1,
    e_send1 = 2'd2
  } steer_state_e;

endpackage

`default_nettype wire

//--- filelist.f
common/switch_pkg.sv
hw/addr_split_decode.sv
hw/send_steer.sv
hw/return_merge.sv
hw/switch_1x2.sv
testbench/tb_switch_1x2.sv

//--- hw/addr_split_decode.sv
`timescale 1ns/1ns
`default_nettype none

module addr_split_decode #(
  parameter int unsigned split_addr_p = 'h2000
) (
  input  switch_pkg::req_pkt_s req_i,
  output logic                 sel_o
);
  import switch_pkg::*;

  localparam epa_t split_epa_lp = epa_t'(split_addr_p);

  epa_t epa;

  assign epa   = {req_i.addr, req_i.part_sel}; // word address scaled to bytes.
  assign sel_o = (epa >= split_epa_lp);        // upper region goes to endpoint 1.

endmodule

`default_nettype wire

//--- hw/return_merge.sv
`timescale 1ns/1ns
`default_nettype none

module return_merge (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  switch_pkg::ret_pkt_s [1:0] ep_ret_i,
  input  logic [1:0]                 ep_ret_v_i,
  output logic [1:0]                 ep_ret_ready_o,
  output switch_pkg::ret_pkt_s       ret_o,
  output logic                       ret_v_o,
  input  logic                       ret_ready_i,
  output logic                       ret_done_o
);

  logic last_r;
  logic hold_r;
  logic hold_sel_r;
  logic rr_sel;
  logic grant;

  // on a tie the input not served last wins.
  assign rr_sel = (&ep_ret_v_i) ? ~last_r : ep_ret_v_i[1];

  // a stalled grant stays put so the output packet holds.
  assign grant = hold_r ? hold_sel_r : rr_sel;

  assign ret_v_o    = ep_ret_v_i[grant];
  assign ret_o      = ep_ret_i[grant];
  assign ret_done_o = ret_v_o & ret_ready_i;

  assign ep_ret_ready_o[0] = ret_done_o & ~grant;
  assign ep_ret_ready_o[1] = ret_done_o &  grant;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      last_r     <= 1'b1; // input 0 first.
      hold_r     <= 1'b0;
      hold_sel_r <= 1'b0;
    end else begin
      if (ret_done_o) begin
        last_r <= grant;
      end
      hold_r     <= ret_v_o & ~ret_ready_i;
      hold_sel_r <= grant;
    end
  end

  assert property (@(posedge clk_i) disable iff (reset_i) ret_done_o |-> ret_v_o)
    else $error("return_merge: transfer without valid.");

  // relies on the endpoints holding their packets while stalled.
  assert property (@(posedge clk_i) disable iff (reset_i)
                   ret_v_o && !ret_ready_i |=> ret_v_o && $stable(ret_o))
    else $error("return_merge: return packet changed under back-pressure.");

endmodule

`default_nettype wire

//--- hw/send_steer.sv
`timescale 1ns/1ns
`default_nettype none

module send_steer #(
  parameter int unsigned max_outstanding_p = 127
) (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       req_v_i,
  input  logic       sel_i,
  output logic       req_ready_o,
  output logic [1:0] ep_v_o,
  input  logic [1:0] ep_ready_i,
  input  logic       ret_done_i
);
  import switch_pkg::*;

  localparam int cnt_width_lp = $clog2(max_outstanding_p + 1);
  localparam logic [cnt_width_lp-1:0] cnt_max_lp = cnt_width_lp'(max_outstanding_p);

  steer_state_e state_r;
  steer_state_e state_n;

  logic [cnt_width_lp-1:0] cnt_r;

  logic is_send0;
  logic is_send1;
  logic req0_v;
  logic req1_v;
  logic credit_ok;
  logic cnt_up;
  logic cnt_zero;

  assign is_send0 = (state_r == e_send0);
  assign is_send1 = (state_r == e_send1);

  assign req0_v = req_v_i & ~sel_i;
  assign req1_v = req_v_i & sel_i;

  // no new request while the counter is full.
  assign credit_ok = (cnt_r != cnt_max_lp);
  assign cnt_zero  = (cnt_r == '0);

  assign ep_v_o[0] = req0_v & is_send0 & credit_ok;
  assign ep_v_o[1] = req1_v & is_send1 & credit_ok;

  assign req_ready_o = credit_ok & ((is_send0 & ~sel_i & ep_ready_i[0])
                                  | (is_send1 &  sel_i & ep_ready_i[1]));

  assign cnt_up = req_v_i & req_ready_o;

  always_comb begin
    state_n = state_r;
    case (state_r)
      e_ready: begin
        if (req_v_i) begin
          state_n = sel_i ? e_send1 : e_send0;
        end
      end
      e_send0: begin
        if (cnt_zero && !req0_v) begin // drained so free to switch.
          state_n = e_ready;
        end
      end
      e_send1: begin
        if (cnt_zero && !req1_v) begin
          state_n = e_ready;
        end
      end
      default: state_n = e_ready;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_ready;
    end else begin
      state_r <= state_n;
    end
  end

  // outstanding requests go up on a forward and down on a return.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_r <= '0;
    end else if (cnt_up && !ret_done_i) begin
      cnt_r <= cnt_r + 1'b1;
    end else if (!cnt_up && ret_done_i) begin
      cnt_r <= cnt_r - 1'b1;
    end
  end

  // a full counter can only leave the limit through a return.
  assert property (@(posedge clk_i) disable iff (reset_i)
                   cnt_r == cnt_max_lp && !ret_done_i |=> cnt_r == cnt_max_lp)
    else $error("send_steer: outstanding count wrapped past the limit.");

  // a return from the merge always matches a request already counted.
  assert property (@(posedge clk_i) disable iff (reset_i) ret_done_i |-> !cnt_zero)
    else $error("send_steer: return with no outstanding request.");

  assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(ep_v_o))
    else $error("send_steer: both endpoint valids high.");

endmodule

`default_nettype wire

//--- hw/switch_1x2.sv
`timescale 1ns/1ns
`default_nettype none

module switch_1x2 #(
  parameter int unsigned split_addr_p      = 'h2000,
  parameter int unsigned max_outstanding_p = 127
) (
  input  logic                       clk_i,
  input  logic                       reset_i,

  input  switch_pkg::req_pkt_s       multi_req_i,
  input  logic                       multi_req_v_i,
  output logic                       multi_req_ready_o,

  output switch_pkg::req_pkt_s [1:0] ep_req_o,
  output logic [1:0]                 ep_req_v_o,
  input  logic [1:0]                 ep_req_ready_i,

  input  switch_pkg::ret_pkt_s [1:0] ep_ret_i,
  input  logic [1:0]                 ep_ret_v_i,
  output logic [1:0]                 ep_ret_ready_o,

  output switch_pkg::ret_pkt_s       multi_ret_o,
  output logic                       multi_ret_v_o,
  input  logic                       multi_ret_ready_i
);

  logic sel;
  logic ret_done;

  // same packet to both, only the valids differ.
  assign ep_req_o[0] = multi_req_i;
  assign ep_req_o[1] = multi_req_i;

  addr_split_decode #(
    .split_addr_p(split_addr_p)
  ) u_decode (
    .req_i(multi_req_i),
    .sel_o(sel)
  );

  send_steer #(
    .max_outstanding_p(max_outstanding_p)
  ) u_steer (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .req_v_i    (multi_req_v_i),
    .sel_i      (sel),
    .req_ready_o(multi_req_ready_o),
    .ep_v_o     (ep_req_v_o),
    .ep_ready_i (ep_req_ready_i),
    .ret_done_i (ret_done)
  );

  return_merge u_merge (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .ep_ret_i      (ep_ret_i),
    .ep_ret_v_i    (ep_ret_v_i),
    .ep_ret_ready_o(ep_ret_ready_o),
    .ret_o         (multi_ret_o),
    .ret_v_o       (multi_ret_v_o),
    .ret_ready_i   (multi_ret_ready_i),
    .ret_done_o    (ret_done)
  );

endmodule

`default_nettype wire

//--- testbench/tb_switch_1x2.sv
`timescale 1ns/1ns
`default_nettype none

module tb_switch_1x2;
  import switch_pkg::*;

  localparam int clk_period_lp = 4;
  localparam int n_req_lp      = 300;
  localparam int split_addr_lp = 'h2000;
  localparam logic [31:0] seed_lp = 32'd28858;

  logic               clk_i = 1'b0;
  logic               reset_i;
  req_pkt_s           multi_req_i;
  logic               multi_req_v_i;
  logic               multi_req_ready_o;
  req_pkt_s [1:0]     ep_req_o;
  logic [1:0]         ep_req_v_o;
  logic [1:0]         ep_req_ready_i;
  ret_pkt_s [1:0]     ep_ret_i;
  logic [1:0]         ep_ret_v_i;
  logic [1:0]         ep_ret_ready_o;
  ret_pkt_s           multi_ret_o;
  logic               multi_ret_v_o;
  logic               multi_ret_ready_i;

  req_pkt_s    stim [n_req_lp];
  int          ep_list [2][n_req_lp]; // stimulus indices queued at each endpoint.
  int          ep_head [2];
  int          ep_tail [2];
  logic [1:0]  ret_shown;
  int          fwd_idx;
  int          ret_cnt;
  logic [31:0] stim_rng;
  logic [31:0] drv_rng;
  logic [31:0] ep_rng [2];
  logic [31:0] mret_rng;
  logic [1:0]  req_stall;
  req_pkt_s    held_req [2];
  logic        ret_stall;
  ret_pkt_s    held_ret;

  switch_1x2 #(
    .split_addr_p(split_addr_lp)
  ) u_dut (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .multi_req_i      (multi_req_i),
    .multi_req_v_i    (multi_req_v_i),
    .multi_req_ready_o(multi_req_ready_o),
    .ep_req_o         (ep_req_o),
    .ep_req_v_o       (ep_req_v_o),
    .ep_req_ready_i   (ep_req_ready_i),
    .ep_ret_i         (ep_ret_i),
    .ep_ret_v_i       (ep_ret_v_i),
    .ep_ret_ready_o   (ep_ret_ready_o),
    .multi_ret_o      (multi_ret_o),
    .multi_ret_v_o    (multi_ret_v_o),
    .multi_ret_ready_i(multi_ret_ready_i)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // byte addresses below the split go to endpoint 0.
  function automatic int exp_endpoint(input req_pkt_s req);
    int byte_addr;
    byte_addr = int'(req.addr) * 4 + int'(req.part_sel);
    return (byte_addr < split_addr_lp) ? 0 : 1;
  endfunction

  function automatic ret_pkt_s exp_return(input req_pkt_s req);
    ret_pkt_s r;
    r.data   = req.data ^ 32'hA5A5A5A5;
    r.src_id = req.src_id;
    return r;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("Simulation failed");
      $fatal(1, "stopping at first mismatch.");
    end
  endtask

  initial begin
    forever #(clk_period_lp / 2) clk_i = ~clk_i;
  end

  initial begin
    #((n_req_lp * 40 + 16) * clk_period_lp);
    $display("Timeout: not all requests were answered in time.");
    $display("Simulation failed");
    $fatal(1, "watchdog expired.");
  end

  // endpoint models and multi return back-pressure.
  always @(negedge clk_i) begin
    ret_pkt_s rp;
    for (int i = 0; i < 2; i++) begin
      ep_rng[i] = xorshift(ep_rng[i]);
      ep_req_ready_i[i] = !reset_i && (ep_rng[i][1:0] != 2'b00);
      if (reset_i) begin
        ep_ret_v_i[i] = 1'b0;
      end else if (!ret_shown[i]) begin
        if (ep_head[i] != ep_tail[i] && ep_rng[i][4:3] == 2'b00) begin // random delay.
          rp.data       = stim[ep_list[i][ep_head[i]]].data ^ 32'hA5A5A5A5;
          rp.src_id     = stim[ep_list[i][ep_head[i]]].src_id;
          ep_ret_i[i]   = rp;
          ep_ret_v_i[i] = 1'b1;
          ret_shown[i]  = 1'b1;
        end else begin
          ep_ret_v_i[i] = 1'b0;
        end
      end
    end
    mret_rng = xorshift(mret_rng);
    multi_ret_ready_i = !reset_i && (mret_rng[1:0] != 2'b00);
  end

  // samples every transfer at the rising edge.
  always @(posedge clk_i) begin
    req_pkt_s   fwd;
    logic [1:0] ret_fire;
    int         hit;
    if (!reset_i) begin
      for (int i = 0; i < 2; i++) begin
        if (req_stall[i]) begin // held request must stay put.
          check_value($sformatf("ep_req_v_o[%0d]", i), ep_req_v_o[i], 1'b1);
          check_value($sformatf("ep_req_o[%0d]", i), ep_req_o[i], held_req[i]);
        end
        req_stall[i] = ep_req_v_o[i] & ~ep_req_ready_i[i];
        held_req[i]  = ep_req_o[i];
      end
      check_value("multi_req_ready_o", |(ep_req_v_o & ep_req_ready_i),
                  multi_req_v_i & multi_req_ready_o);
      for (int i = 0; i < 2; i++) begin
        if (ep_req_v_o[i] && ep_req_ready_i[i]) begin
          fwd = stim[fwd_idx];
          check_value("endpoint select", i, exp_endpoint(fwd));
          check_value($sformatf("ep_req_o[%0d]", i), ep_req_o[i], fwd);
          check_value($sformatf("outstanding at endpoint %0d", 1 - i),
                      ep_tail[1-i] - ep_head[1-i], 0);
          ep_list[i][ep_tail[i]] = fwd_idx;
          ep_tail[i] = ep_tail[i] + 1;
          fwd_idx = fwd_idx + 1;
        end
      end
      if (ret_stall) begin
        check_value("multi_ret_v_o", multi_ret_v_o, 1'b1);
        check_value("multi_ret_o", multi_ret_o, held_ret);
      end
      ret_stall = multi_ret_v_o & ~multi_ret_ready_i;
      held_ret  = multi_ret_o;
      ret_fire  = ep_ret_v_i & ep_ret_ready_o;
      check_value("ep_ret_ready_o", ret_fire != 2'b00, multi_ret_v_o & multi_ret_ready_i);
      if (multi_ret_v_o && multi_ret_ready_i) begin
        check_value("ep_ret_ready_o count", $countones(ret_fire), 1);
        hit = ret_fire[1] ? 1 : 0;
        check_value($sformatf("returns pending at endpoint %0d", hit),
                    ep_head[hit] < ep_tail[hit], 1'b1);
        check_value("multi_ret_o", multi_ret_o, exp_return(stim[ep_list[hit][ep_head[hit]]]));
        ep_head[hit]   = ep_head[hit] + 1;
        ret_shown[hit] = 1'b0;
        ret_cnt        = ret_cnt + 1;
      end
    end
  end

  initial begin
    int gap;
    reset_i           = 1'b1;
    multi_req_i       = '0;
    multi_req_v_i     = 1'b0;
    ep_req_ready_i    = '0;
    ep_ret_i          = '0;
    ep_ret_v_i        = '0;
    multi_ret_ready_i = 1'b0;
    ret_shown         = '0;
    req_stall         = '0;
    ret_stall         = 1'b0;
    fwd_idx           = 0;
    ret_cnt           = 0;
    ep_head           = '{0, 0};
    ep_tail           = '{0, 0};
    stim_rng          = seed_lp;
    drv_rng           = xorshift(seed_lp ^ 32'h1111);
    ep_rng[0]         = xorshift(seed_lp ^ 32'h2222);
    ep_rng[1]         = xorshift(seed_lp ^ 32'h3333);
    mret_rng          = xorshift(seed_lp ^ 32'h4444);

    for (int k = 0; k < n_req_lp; k++) begin
      stim_rng = xorshift(stim_rng);
      stim[k].addr     = addr_t'(14'h7e0 + stim_rng[5:0]); // straddles the split.
      stim[k].part_sel = stim_rng[7:6];
      stim[k].src_id   = stim_rng[11:8];
      stim_rng = xorshift(stim_rng);
      stim[k].data     = stim_rng;
    end

    repeat (16) @(negedge clk_i);
    reset_i = 1'b0;
    repeat (4) begin
      @(posedge clk_i);
      check_value("ep_req_v_o", ep_req_v_o, 2'b00);
      check_value("multi_req_ready_o", multi_req_ready_o, 1'b0);
      check_value("multi_ret_v_o", multi_ret_v_o, 1'b0);
    end

    @(negedge clk_i);
    for (int k = 0; k < n_req_lp; k++) begin
      drv_rng = xorshift(drv_rng);
      gap = drv_rng[2] ? int'(drv_rng[1:0]) : 0;
      if (gap != 0) begin
        multi_req_v_i = 1'b0;
        repeat (gap) @(negedge clk_i);
      end
      multi_req_i   = stim[k];
      multi_req_v_i = 1'b1;
      do @(posedge clk_i); while (!multi_req_ready_o);
      @(negedge clk_i);
    end
    multi_req_v_i = 1'b0;

    wait (ret_cnt == n_req_lp);
    repeat (4) @(posedge clk_i);
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire
